/* asrm_arch_pkg.sv */
// ##########################################################
// asrm architecture definitions: data word, register index,
// program address and the special register numbers
// ##########################################################

package asrm_arch_pkg;

    // one data word, matches the wordsize parameter of the core
    typedef logic [15:0] word_t;

    // index into the sixteen-entry register file
    typedef logic [3:0] reg_id_t;

    // program address, low bits of the program counter
    typedef logic [7:0] pc_addr_t;

    // working register, target of most operations
    localparam reg_id_t WR_ID = 4'd0;

    // jump target source for the system group
    localparam reg_id_t JMP_SRC_ID = 4'd1;

    // status register, bit 0 holds the last comparison
    localparam reg_id_t SR_ID = 4'd14;

    // program counter
    localparam reg_id_t PC_ID = 4'd15;

endpackage

/* asrm_isa_pkg.sv */
// ##########################################################
// asrm instruction set: instruction type, opcodes and the
// full encodings of the system group
// ##########################################################

package asrm_isa_pkg;

    // upper nibble opcode, lower nibble register or immediate
    typedef logic [7:0] instr_t;

    // codes 14 and 15 are unused and write 0 to the working register
    typedef enum logic [3:0] {
        OP_SYS  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_NOT  = 4'd6,
        OP_LSL  = 4'd7,
        OP_LSR  = 4'd8,
        OP_CPY  = 4'd9,
        OP_SET  = 4'd10,
        OP_READ = 4'd11,
        OP_EQ   = 4'd12,
        OP_LES  = 4'd13
    } opcode_e;

    // system group, anything else in the group behaves as slp
    localparam instr_t INST_SLP = 8'h00;
    localparam instr_t INST_JMP = 8'h01;
    localparam instr_t INST_JIF = 8'h02;

    function automatic opcode_e get_opcode(input instr_t inst);
        return opcode_e'(inst[7:4]);
    endfunction

endpackage

/* asrm_alu.sv */
// ##########################################################
// asrm ALU: combinational result and destination register
// for one instruction
// ##########################################################

`timescale 1ns/1ps

module asrm_alu #(
    parameter int wordsize = 16
) (
    input  asrm_arch_pkg::word_t   working_register,
    input  asrm_arch_pkg::word_t   other_register,
    input  asrm_arch_pkg::word_t   status_register,
    input  asrm_isa_pkg::instr_t   instruction,
    output asrm_arch_pkg::word_t   out,
    output asrm_arch_pkg::reg_id_t out_reg
);

    localparam logic [wordsize-1:0] zero_word = '0;

    wire asrm_isa_pkg::opcode_e opcode = asrm_isa_pkg::get_opcode(instruction);

    // system group decode
    wire is_sys    = (opcode == asrm_isa_pkg::OP_SYS);
    wire is_jmp    = (instruction == asrm_isa_pkg::INST_JMP);
    wire is_jif    = (instruction == asrm_isa_pkg::INST_JIF);
    wire jif_taken = is_jif && status_register[0];
    // slp and every undefined system code
    wire is_slp    = is_sys && !is_jmp && !is_jif;

    // arithmetic
    wire asrm_arch_pkg::word_t add_out = (opcode == asrm_isa_pkg::OP_ADD)
        ? working_register + other_register : zero_word;
    wire asrm_arch_pkg::word_t sub_out = (opcode == asrm_isa_pkg::OP_SUB)
        ? working_register - other_register : zero_word;

    // logic and shifts
    wire asrm_arch_pkg::word_t and_out = (opcode == asrm_isa_pkg::OP_AND)
        ? working_register & other_register : zero_word;
    wire asrm_arch_pkg::word_t or_out = (opcode == asrm_isa_pkg::OP_OR)
        ? working_register | other_register : zero_word;
    wire asrm_arch_pkg::word_t xor_out = (opcode == asrm_isa_pkg::OP_XOR)
        ? working_register ^ other_register : zero_word;
    wire asrm_arch_pkg::word_t not_out = (opcode == asrm_isa_pkg::OP_NOT)
        ? ~other_register : zero_word;
    wire asrm_arch_pkg::word_t lsl_out = (opcode == asrm_isa_pkg::OP_LSL)
        ? working_register << other_register : zero_word;
    wire asrm_arch_pkg::word_t lsr_out = (opcode == asrm_isa_pkg::OP_LSR)
        ? working_register >> other_register : zero_word;

    // slp, cpy and untaken jif pass the working register
    wire asrm_arch_pkg::word_t raw_out =
        (is_slp || (opcode == asrm_isa_pkg::OP_CPY) || (is_jif && !status_register[0]))
        ? working_register : zero_word;
    // immediate, zero extended
    wire asrm_arch_pkg::word_t set_out = (opcode == asrm_isa_pkg::OP_SET)
        ? asrm_arch_pkg::word_t'(instruction[3:0]) : zero_word;
    // read and taken jumps pass the other register
    wire asrm_arch_pkg::word_t oth_out =
        ((opcode == asrm_isa_pkg::OP_READ) || is_jmp || jif_taken)
        ? other_register : zero_word;

    wire asrm_arch_pkg::word_t out_nocmp = add_out | sub_out | and_out | or_out | xor_out
        | not_out | lsl_out | lsr_out | raw_out | set_out | oth_out;

    wire asrm_arch_pkg::reg_id_t out_reg_nocmp =
        (opcode == asrm_isa_pkg::OP_CPY) ? instruction[3:0]
        : (is_jmp || jif_taken) ? asrm_arch_pkg::PC_ID
        : asrm_arch_pkg::WR_ID;

    // comparisons only touch bit 0 of the status register
    wire cmp_eq  = (opcode == asrm_isa_pkg::OP_EQ) && (working_register == other_register);
    wire cmp_les = (opcode == asrm_isa_pkg::OP_LES) && (working_register < other_register);
    wire cmp_op  = (opcode == asrm_isa_pkg::OP_EQ) || (opcode == asrm_isa_pkg::OP_LES);
    wire asrm_arch_pkg::word_t out_cmp = {status_register[wordsize-1:1], cmp_eq | cmp_les};

    assign out     = cmp_op ? out_cmp : out_nocmp;
    assign out_reg = cmp_op ? asrm_arch_pkg::SR_ID : out_reg_nocmp;

endmodule

/* asrm_regfile.sv */
// ##########################################################
// asrm register file: sixteen registers, one write port and
// the program counter step on every non-jump write
// ##########################################################

`timescale 1ns/1ps

module asrm_regfile #(
    parameter int wordsize = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  asrm_arch_pkg::reg_id_t rd_id,
    output asrm_arch_pkg::word_t   rd_data,
    output asrm_arch_pkg::word_t   jmp_src,
    output asrm_arch_pkg::word_t   wr_value,
    output asrm_arch_pkg::word_t   sr_value,
    output asrm_arch_pkg::word_t   pc,
    input  logic                   wr_en,
    input  asrm_arch_pkg::reg_id_t wr_id,
    input  asrm_arch_pkg::word_t   wr_data
);

    logic [wordsize-1:0] regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_id] <= wr_data;
            // a write to the pc is a jump, no step
            if (wr_id != asrm_arch_pkg::PC_ID) begin
                regs[asrm_arch_pkg::PC_ID] <= regs[asrm_arch_pkg::PC_ID] + 1'b1;
            end
        end
    end

    // combinational reads
    assign rd_data  = regs[rd_id];
    assign jmp_src  = regs[asrm_arch_pkg::JMP_SRC_ID];
    assign wr_value = regs[asrm_arch_pkg::WR_ID];
    assign sr_value = regs[asrm_arch_pkg::SR_ID];
    assign pc       = regs[asrm_arch_pkg::PC_ID];

    // the written value is visible one cycle after the strobe
    a_write_lands: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |=> regs[$past(wr_id)] == $past(wr_data)
    ) else $error("regfile write to r%0d did not land", $past(wr_id));

endmodule

/* asrm_prog_mem.sv */
// ##########################################################
// asrm program memory: host-written bytes, registered read
// for instruction fetch
// ##########################################################

`timescale 1ns/1ps

module asrm_prog_mem #(
    parameter int prog_depth = 256
) (
    input  logic                    clk,
    input  logic                    load_valid,
    input  asrm_arch_pkg::pc_addr_t load_addr,
    input  asrm_isa_pkg::instr_t    load_data,
    input  asrm_arch_pkg::pc_addr_t fetch_addr,
    output asrm_isa_pkg::instr_t    fetch_data
);

    // smaller depths use only the low address bits
    localparam int aw = $clog2(prog_depth);

    asrm_isa_pkg::instr_t mem [prog_depth];

    // host load port
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr[aw-1:0]] <= load_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_addr[aw-1:0]];
    end

endmodule

/* asrm_sequencer.sv */
// ##########################################################
// asrm sequencer: fetch/execute FSM with run and halt control
// and the write-back strobe
// ##########################################################

`timescale 1ns/1ps

module asrm_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  asrm_arch_pkg::word_t    pc,
    output asrm_arch_pkg::pc_addr_t fetch_addr,
    input  asrm_isa_pkg::instr_t    fetch_data,
    output asrm_isa_pkg::instr_t    instr,
    output logic                    use_jmp_src,
    input  asrm_arch_pkg::word_t    alu_out,
    input  asrm_arch_pkg::reg_id_t  alu_out_reg,
    output logic                    wr_en,
    output asrm_arch_pkg::reg_id_t  wr_id,
    output asrm_arch_pkg::word_t    wr_data,
    output logic                    halted
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   is_sys;
    logic   stop;

    // pc holds still until the end of exec, so the registered
    // memory output stays valid for the whole exec cycle
    assign fetch_addr = pc[$bits(asrm_arch_pkg::pc_addr_t)-1:0];
    assign instr      = fetch_data;

    assign is_sys = (asrm_isa_pkg::get_opcode(instr) == asrm_isa_pkg::OP_SYS);
    // jmp and jif keep running, the rest of the group sleeps
    assign stop = is_sys && (instr != asrm_isa_pkg::INST_JMP)
        && (instr != asrm_isa_pkg::INST_JIF);

    // system group reads register 1 as its other operand
    assign use_jmp_src = is_sys;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (run) begin
                    state_nxt = ST_FETCH;
                end
            end
            ST_FETCH: state_nxt = ST_EXEC;
            ST_EXEC:  state_nxt = stop ? ST_IDLE : ST_FETCH;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // write-back straight from the ALU
    assign wr_en   = (state == ST_EXEC);
    assign wr_id   = alu_out_reg;
    assign wr_data = alu_out;
    assign halted  = (state == ST_IDLE);

    // executed instruction comes from the pc seen in fetch
    a_pc_held_in_exec: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> $stable(pc)
    ) else $error("pc moved between fetch and execute");

    // a run while halted gives a fetch, then a write-back
    a_run_starts: assert property (
        @(posedge clk) disable iff (rst)
        (run && halted) |=> (state == ST_FETCH) ##1 wr_en
    ) else $error("run strobe did not start an instruction");

endmodule

/* asrm_cpu.sv */
// ##########################################################
// asrm cpu top: program memory, sequencer, register file
// and ALU
// ##########################################################

`timescale 1ns/1ps

module asrm_cpu #(
    parameter int wordsize   = 16,
    parameter int prog_depth = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_valid,
    input  asrm_arch_pkg::pc_addr_t load_addr,
    input  asrm_isa_pkg::instr_t    load_data,
    input  logic                    run,
    output logic                    wb_valid,
    output asrm_arch_pkg::reg_id_t  wb_reg,
    output asrm_arch_pkg::word_t    wb_data,
    output logic                    halted
);

    asrm_arch_pkg::pc_addr_t fetch_addr;
    asrm_isa_pkg::instr_t    fetch_data;
    asrm_isa_pkg::instr_t    instr;
    logic                    use_jmp_src;
    asrm_arch_pkg::word_t    rd_data;
    asrm_arch_pkg::word_t    jmp_src;
    asrm_arch_pkg::word_t    wr_value;
    asrm_arch_pkg::word_t    sr_value;
    asrm_arch_pkg::word_t    pc;
    asrm_arch_pkg::word_t    other_value;
    asrm_arch_pkg::word_t    alu_out;
    asrm_arch_pkg::reg_id_t  alu_out_reg;

    asrm_prog_mem #(
        .prog_depth (prog_depth)
    ) i_prog_mem (
        .clk        (clk),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    asrm_sequencer i_sequencer (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .pc          (pc),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .instr       (instr),
        .use_jmp_src (use_jmp_src),
        .alu_out     (alu_out),
        .alu_out_reg (alu_out_reg),
        .wr_en       (wb_valid),
        .wr_id       (wb_reg),
        .wr_data     (wb_data),
        .halted      (halted)
    );

    asrm_regfile #(
        .wordsize (wordsize)
    ) i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rd_id    (instr[3:0]),
        .rd_data  (rd_data),
        .jmp_src  (jmp_src),
        .wr_value (wr_value),
        .sr_value (sr_value),
        .pc       (pc),
        .wr_en    (wb_valid),
        .wr_id    (wb_reg),
        .wr_data  (wb_data)
    );

    // register 1 feeds jumps, the low nibble picks it otherwise
    assign other_value = use_jmp_src ? jmp_src : rd_data;

    asrm_alu #(
        .wordsize (wordsize)
    ) i_alu (
        .working_register (wr_value),
        .other_register   (other_value),
        .status_register  (sr_value),
        .instruction      (instr),
        .out              (alu_out),
        .out_reg          (alu_out_reg)
    );

endmodule

/* asrm_ref_model.svh */
// ##########################################################
// asrm instruction-set model: register file, program image
// and one-instruction step
// ##########################################################

`ifndef ASRM_REF_MODEL_SVH
`define ASRM_REF_MODEL_SVH

asrm_arch_pkg::word_t model_regs [16];
asrm_isa_pkg::instr_t model_prog [256];
logic                 model_halted;

task automatic model_reset();
    for (int i = 0; i < 16; i++) begin
        model_regs[i] = '0;
    end
    model_halted = 1'b1;
endtask

// executes the instruction at the pc and returns its write-back
task automatic model_step(output asrm_arch_pkg::reg_id_t exp_reg,
                          output asrm_arch_pkg::word_t exp_data);
    asrm_isa_pkg::instr_t   inst;
    logic [3:0]             op;
    asrm_arch_pkg::reg_id_t low;
    asrm_arch_pkg::word_t   w;
    asrm_arch_pkg::word_t   o;
    asrm_arch_pkg::word_t   sr;
    inst = model_prog[model_regs[asrm_arch_pkg::PC_ID][7:0]];
    op   = inst[7:4];
    low  = inst[3:0];
    w    = model_regs[asrm_arch_pkg::WR_ID];
    sr   = model_regs[asrm_arch_pkg::SR_ID];
    // system group always looks at register 1
    o    = (op == 4'd0) ? model_regs[asrm_arch_pkg::JMP_SRC_ID] : model_regs[low];
    exp_reg  = asrm_arch_pkg::WR_ID;
    exp_data = w;
    model_halted = 1'b0;
    case (op)
        4'd0: begin
            if (inst == 8'h01 || (inst == 8'h02 && sr[0])) begin
                exp_reg  = asrm_arch_pkg::PC_ID;
                exp_data = o;
            end else if (inst != 8'h02) begin
                model_halted = 1'b1;
            end
        end
        4'd1:  exp_data = w + o;
        4'd2:  exp_data = w - o;
        4'd3:  exp_data = w & o;
        4'd4:  exp_data = w | o;
        4'd5:  exp_data = w ^ o;
        4'd6:  exp_data = ~o;
        4'd7:  exp_data = w << o;
        4'd8:  exp_data = w >> o;
        4'd9:  exp_reg  = low;
        4'd10: exp_data = asrm_arch_pkg::word_t'(low);
        4'd11: exp_data = o;
        4'd12: begin
            exp_reg  = asrm_arch_pkg::SR_ID;
            exp_data = {sr[15:1], w == o};
        end
        4'd13: begin
            exp_reg  = asrm_arch_pkg::SR_ID;
            exp_data = {sr[15:1], w < o};
        end
        default: exp_data = '0;
    endcase
    model_regs[exp_reg] = exp_data;
    if (exp_reg != asrm_arch_pkg::PC_ID) begin
        model_regs[asrm_arch_pkg::PC_ID] = model_regs[asrm_arch_pkg::PC_ID] + 1'b1;
    end
endtask

`endif

/* tb_asrm_cpu.sv */
// ##########################################################
// asrm cpu testbench: random programs checked write-back by
// write-back against the instruction-set model
// ##########################################################

`timescale 1ns/1ps

module tb_asrm_cpu;

    localparam int    num_programs = 9;
    localparam int    wb_limit     = 64;
    localparam int    clk_period   = 40;
    // load, reset and a run restart per write-back in the worst case
    localparam int    prog_cycles  = 256 + 8 + wb_limit * 2 * 2;
    localparam longint watchdog_ns = longint'(num_programs) * prog_cycles * clk_period
        + 2000 * clk_period;

    logic                    clk;
    logic                    rst;
    logic                    load_valid;
    asrm_arch_pkg::pc_addr_t load_addr;
    asrm_isa_pkg::instr_t    load_data;
    logic                    run;
    logic                    wb_valid;
    asrm_arch_pkg::reg_id_t  wb_reg;
    asrm_arch_pkg::word_t    wb_data;
    logic                    halted;
    logic [31:0]             lcg_state;

    `include "asrm_ref_model.svh"

    asrm_cpu #(
        .wordsize   (16),
        .prog_depth (256)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .run        (run),
        .wb_valid   (wb_valid),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_reg(input string name, input asrm_arch_pkg::reg_id_t got,
                             input asrm_arch_pkg::reg_id_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input string name, input asrm_arch_pkg::word_t got,
                              input asrm_arch_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_halted(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: halted = 0x%h, expected 0x%h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    // mode 0 straight-line alu ops, mode 1 adds compares and
    // the system group, mode 2 raw random bytes
    task automatic make_program(input int mode);
        logic [15:0] r;
        logic [3:0]  op;
        logic [3:0]  low;
        for (int a = 0; a < 256; a++) begin
            r   = next_rand();
            low = r[15:12];
            if (mode == 0) begin
                op = 4'(1 + r % 11);
            end else if (mode == 1) begin
                op = 4'(r % 14);
                if (op == 4'd0) begin
                    low = 4'(r[15:8] % 3);
                end
            end else begin
                op = r[3:0];
            end
            model_prog[a] = {op, low};
        end
    endtask

    // whole image goes in, the machine must stay asleep meanwhile
    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr  <= asrm_arch_pkg::pc_addr_t'(a);
            load_data  <= model_prog[a];
            @(negedge clk);
            check_halted(halted, 1'b1);
            if (wb_valid) begin
                $display("write-back strobe seen while halted and loading");
                stop_with_failure();
            end
        end
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
    endtask

    // fetch then execute, so each write-back is 2 cycles on
    task automatic wait_wb();
        int gap;
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
            if (gap > 6) begin
                $display("no write-back within %0d cycles", gap);
                stop_with_failure();
            end
        end while (!wb_valid);
        if (gap != 2) begin
            $display("write-back came after %0d cycles instead of 2", gap);
            stop_with_failure();
        end
    endtask

    task automatic run_program();
        int                     count;
        asrm_arch_pkg::reg_id_t exp_reg;
        asrm_arch_pkg::word_t   exp_data;
        count = 0;
        while (count < wb_limit) begin
            start_run();
            do begin
                wait_wb();
                model_step(exp_reg, exp_data);
                check_reg("wb_reg", wb_reg, exp_reg);
                check_word("wb_data", wb_data, exp_data);
                check_halted(halted, 1'b0);
                count++;
            end while (!model_halted && count < wb_limit);
            if (model_halted) begin
                @(negedge clk);
                check_halted(halted, 1'b1);
                if (wb_valid) begin
                    $display("write-back strobe seen after the machine went to sleep");
                    stop_with_failure();
                end
            end
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the DUT stopped responding", watchdog_ns);
        stop_with_failure();
    end

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        lcg_state  = 32'd56;
        for (int p = 0; p < num_programs; p++) begin
            apply_reset();
            model_reset();
            make_program(p % 3);
            load_program();
            run_program();
        end
        $display("All checks passed");
        $finish;
    end

endmodule

/* asrm_cpu.f */
+incdir+.
asrm_arch_pkg.sv
asrm_isa_pkg.sv
asrm_alu.sv
asrm_regfile.sv
asrm_prog_mem.sv
asrm_sequencer.sv
asrm_cpu.sv
tb_asrm_cpu.sv
